//--- Bender.yml
package:
  name: cholesky

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/chol_pkg.sv
      - logic/chol_matrix_store.sv
      - logic/chol_mac.sv
      - logic/chol_sqrt.sv
      - logic/chol_div.sv
      - logic/chol_ctrl.sv
      - logic/cholesky_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clock.sv
      - test/cholesky_tb.sv

//--- include/chol_consts.svh
`ifndef CHOL_CONSTS_SVH
`define CHOL_CONSTS_SVH

// Matrix order
`define CHOL_N 5

// Fixed-point word, signed Q16.16
`define CHOL_WORD 32
`define CHOL_FRAC 16

// Lower triangle of a CHOL_N x CHOL_N matrix
`define CHOL_ELEMS 15

`endif

//--- logic/chol_ctrl.sv
`include "chol_consts.svh"

module chol_ctrl
    import chol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      a_valid,
    input  fix_t      rd_data_a,
    input  fix_t      rd_data_b,
    input  fix_t      residual,
    input  fix_t      root,
    input  fix_t      quot,
    input  logic      sqrt_done,
    input  logic      div_done,
    output logic      load,
    output logic      wr_en,
    output elem_idx_t wr_addr,
    output fix_t      wr_data,
    output elem_idx_t rd_addr_a,
    output elem_idx_t rd_addr_b,
    output fix_t      mac_c,
    output logic      mac_clr,
    output logic      mac_acc_en,
    output logic      sqrt_start,
    output logic      div_start,
    output fix_t      div_den,
    output logic      busy,
    output logic      l_valid
);

    localparam logic [2:0] LAST = 3'(`CHOL_N - 1);

    ctrl_state_t state;
    logic [2:0]  col;  // j
    logic [2:0]  row;  // i, runs j..4
    logic [2:0]  k;    // Inner product index
    logic        accum_step;

    // Word index of element (r, c) in the packed triangle
    function automatic elem_idx_t tri_idx(input logic [2:0] r, input logic [2:0] c);
        logic [5:0] base;
        base = ({3'b000, r} * ({3'b000, r} + 6'd1)) >> 1;
        return elem_idx_t'(base + {3'b000, c});
    endfunction

    // Schedule
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            col   <= '0;
            row   <= '0;
            k     <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (a_valid) begin
                        state <= FETCH;
                        col   <= '0;
                        row   <= '0;
                    end else begin
                        state <= IDLE;
                    end
                end
                FETCH: begin
                    k     <= '0;
                    state <= ACCUM;
                end
                ACCUM: begin
                    if (k == col) begin
                        state <= (row == col) ? SQRT : DIV;  // Residual is ready here
                    end else begin
                        k <= k + 3'd1;
                    end
                end
                SQRT: begin
                    if (sqrt_done) state <= WRITE;
                end
                DIV: begin
                    if (div_done) state <= WRITE;
                end
                WRITE: begin
                    if (row != LAST) begin
                        row   <= row + 3'd1;
                        state <= FETCH;
                    end else if (col != LAST) begin
                        col   <= col + 3'd1;
                        row   <= col + 3'd1;  // Next column starts on its diagonal
                        state <= FETCH;
                    end else begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign busy    = (state != IDLE) && (state != DONE);
    assign l_valid = (state == DONE);
    assign load    = a_valid && !busy;

    // MAC feed
    assign accum_step = (state == ACCUM) && (k != col);
    assign mac_clr    = (state == FETCH);
    assign mac_acc_en = accum_step;
    assign mac_c      = rd_data_a;  // A_ij during FETCH

    // Port a walks row i, port b walks row j, b parks on L_jj otherwise
    assign rd_addr_a = tri_idx(row, accum_step ? k : col);
    assign rd_addr_b = tri_idx(col, accum_step ? k : col);

    assign sqrt_start = (state == ACCUM) && (k == col) && (row == col);
    assign div_start  = (state == ACCUM) && (k == col) && (row != col);
    assign div_den    = rd_data_b;

    // Result back into the store in place of A_ij
    assign wr_en   = (state == WRITE);
    assign wr_addr = tri_idx(row, col);
    assign wr_data = (row == col) ? root : quot;

    // A positive-definite input keeps every diagonal residual non-negative
    diag_residual_pos: assert property (
        @(posedge clk) disable iff (rst)
        sqrt_start |-> !residual[`CHOL_WORD-1]
    );

endmodule

//--- logic/chol_div.sv
`include "chol_consts.svh"

module chol_div
    import chol_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  fix_t num,
    input  fix_t den,
    output fix_t quot,
    output logic done
);

    localparam int DVD_W = `CHOL_WORD + `CHOL_FRAC;  // num scaled by 2^16

    logic [`CHOL_WORD-1:0] num_mag;
    logic [`CHOL_WORD-1:0] den_mag;
    logic [DVD_W-1:0]      q;  // Dividend out at the top, quotient in at the bottom
    logic [`CHOL_WORD-1:0] dmag;
    logic [`CHOL_WORD-1:0] rem;
    logic [`CHOL_WORD:0]   rem_shift;
    logic [`CHOL_WORD:0]   diff;
    logic                  take;
    logic                  neg;
    logic [5:0]            cnt;
    logic                  busy;

    // Magnitudes, -2^31 maps to 2^31 unsigned
    assign num_mag = num[`CHOL_WORD-1] ? -num : num;
    assign den_mag = den[`CHOL_WORD-1] ? -den : den;

    assign rem_shift = {rem, q[DVD_W-1]};
    assign diff      = rem_shift - {1'b0, dmag};
    assign take      = (rem_shift >= {1'b0, dmag});

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 6'(DVD_W);
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            q    <= {num_mag, {`CHOL_FRAC{1'b0}}};
            rem  <= '0;
            dmag <= den_mag;
            neg  <= num[`CHOL_WORD-1] ^ den[`CHOL_WORD-1];
        end else if (busy) begin
            rem <= take ? diff[`CHOL_WORD-1:0] : rem_shift[`CHOL_WORD-1:0];
            q   <= {q[DVD_W-2:0], take};
        end
    end

    // Sign restored on the low word, truncates toward zero
    assign quot = neg ? -q[`CHOL_WORD-1:0] : q[`CHOL_WORD-1:0];

    den_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        start |-> (den != '0)
    );

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    );

endmodule

//--- logic/chol_mac.sv
`include "chol_consts.svh"

module chol_mac
    import chol_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic clr,
    input  logic acc_en,
    input  fix_t c,
    input  fix_t x,
    input  fix_t y,
    output fix_t residual
);

    acc_t acc;
    acc_t prod;

    // Full Q32.32 product, no rounding
    assign prod = x * y;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clr) begin
            acc <= acc_t'(c) <<< `CHOL_FRAC;  // A element into Q32.32
        end else if (acc_en) begin
            acc <= acc - prod;
        end
    end

    // Back to Q16.16
    assign residual = acc[`CHOL_FRAC +: `CHOL_WORD];

endmodule

//--- logic/chol_matrix_store.sv
`include "chol_consts.svh"

module chol_matrix_store
    import chol_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  mat_t      a,
    input  logic      wr_en,
    input  elem_idx_t wr_addr,
    input  fix_t      wr_data,
    input  elem_idx_t rd_addr_a,
    input  elem_idx_t rd_addr_b,
    output fix_t      rd_data_a,
    output fix_t      rd_data_b,
    output mat_t      contents
);

    fix_t mem [`CHOL_ELEMS];

    // Bulk load of A, then L written back word by word
    always_ff @(posedge clk) begin
        if (load) begin
            for (int e = 0; e < `CHOL_ELEMS; e++) begin
                mem[e] <= a[e*`CHOL_WORD +: `CHOL_WORD];
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = mem[rd_addr_a];  // Combinational reads
    assign rd_data_b = mem[rd_addr_b];

    always_comb begin
        for (int e = 0; e < `CHOL_ELEMS; e++) begin
            contents[e*`CHOL_WORD +: `CHOL_WORD] = mem[e];
        end
    end

    // Controller addressing must stay inside the triangle
    wr_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (wr_addr < `CHOL_ELEMS)
    );

endmodule

//--- logic/chol_pkg.sv
`include "chol_consts.svh"

package chol_pkg;

    // One matrix element, signed Q16.16
    typedef logic signed [`CHOL_WORD-1:0] fix_t;

    // Product accumulator, signed Q32.32
    typedef logic signed [2*`CHOL_WORD-1:0] acc_t;

    // Packed lower triangle, word i*(i+1)/2 + j holds element (i, j)
    typedef logic [`CHOL_ELEMS*`CHOL_WORD-1:0] mat_t;

    typedef logic [$clog2(`CHOL_ELEMS)-1:0] elem_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        ACCUM,
        SQRT,
        DIV,
        WRITE,
        DONE
    } ctrl_state_t;

endpackage

//--- logic/chol_sqrt.sv
`include "chol_consts.svh"

module chol_sqrt
    import chol_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  fix_t d,
    output fix_t root,
    output logic done
);

    localparam int RAD_W  = `CHOL_WORD + `CHOL_FRAC;  // d scaled by 2^16
    localparam int ROOT_W = RAD_W / 2;

    logic [RAD_W-1:0]  rad;
    logic [ROOT_W-1:0] q;
    logic [ROOT_W+1:0] rem;
    logic [ROOT_W+3:0] rem_shift;
    logic [ROOT_W+3:0] trial;
    logic [ROOT_W+3:0] diff;
    logic              take;
    logic [4:0]        cnt;
    logic              busy;

    // One restoring step
    // --------------------
    assign rem_shift = {rem, rad[RAD_W-1 -: 2]};
    assign trial     = {2'b00, q, 2'b01};
    assign diff      = rem_shift - trial;
    assign take      = (rem_shift >= trial);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 5'(ROOT_W);
            end else if (busy) begin
                cnt <= cnt - 5'd1;
                if (cnt == 5'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // Last bit lands with this edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // Negative residual clamps to zero
            rad <= d[`CHOL_WORD-1] ? '0 : {d, {`CHOL_FRAC{1'b0}}};
            q   <= '0;
            rem <= '0;
        end else if (busy) begin
            rad <= rad << 2;
            q   <= {q[ROOT_W-2:0], take};
            rem <= take ? diff[ROOT_W+1:0] : rem_shift[ROOT_W+1:0];
        end
    end

    assign root = {{(`CHOL_WORD-ROOT_W){1'b0}}, q};

    no_start_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    );

endmodule

//--- logic/cholesky_top.sv
`include "chol_consts.svh"

module cholesky_top
    import chol_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  mat_t a,
    input  logic a_valid,
    output mat_t l,
    output logic l_valid,
    output logic busy
);

    logic      load;
    logic      wr_en;
    elem_idx_t wr_addr;
    fix_t      wr_data;
    elem_idx_t rd_addr_a;
    elem_idx_t rd_addr_b;
    fix_t      rd_data_a;
    fix_t      rd_data_b;

    fix_t      mac_c;
    logic      mac_clr;
    logic      mac_acc_en;
    fix_t      residual;

    logic      sqrt_start;
    logic      sqrt_done;
    fix_t      root;
    logic      div_start;
    logic      div_done;
    fix_t      div_den;
    fix_t      quot;

    // Storage and scheduling
    // --------------------
    chol_matrix_store i_store (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .a         (a),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .contents  (l)  // L replaces A in place
    );

    chol_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .a_valid    (a_valid),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .residual   (residual),
        .root       (root),
        .quot       (quot),
        .sqrt_done  (sqrt_done),
        .div_done   (div_done),
        .load       (load),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .mac_c      (mac_c),
        .mac_clr    (mac_clr),
        .mac_acc_en (mac_acc_en),
        .sqrt_start (sqrt_start),
        .div_start  (div_start),
        .div_den    (div_den),
        .busy       (busy),
        .l_valid    (l_valid)
    );

    // Arithmetic units
    // --------------------
    chol_mac i_mac (
        .clk      (clk),
        .rst      (rst),
        .clr      (mac_clr),
        .acc_en   (mac_acc_en),
        .c        (mac_c),
        .x        (rd_data_a),  // L_ik
        .y        (rd_data_b),  // L_jk
        .residual (residual)
    );

    chol_sqrt i_sqrt (
        .clk   (clk),
        .rst   (rst),
        .start (sqrt_start),
        .d     (residual),
        .root  (root),
        .done  (sqrt_done)
    );

    chol_div i_div (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .num   (residual),
        .den   (div_den),
        .quot  (quot),
        .done  (div_done)
    );

endmodule

//--- tb.f
+incdir+include
logic/chol_pkg.sv
logic/chol_matrix_store.sv
logic/chol_mac.sv
logic/chol_sqrt.sv
logic/chol_div.sv
logic/chol_ctrl.sv
logic/cholesky_top.sv
test/tb_clock.sv
test/cholesky_tb.sv

//--- test/cholesky_tb.sv
`include "chol_consts.svh"

module cholesky_tb
    import chol_pkg::*;
();

    localparam int SEED        = 66;
    localparam int RANDOM_RUNS = 10;
    localparam int RUN_TIMEOUT = 4000;  // Cycles, a full run is well under 1000
    localparam int IDLE_CYCLES = 1000;

    logic clk;
    logic rst;
    mat_t a;
    logic a_valid;
    mat_t l;
    logic l_valid;
    logic busy;

    mat_t exp_l;
    mat_t stim_first;
    mat_t stim_second;
    int   errors       = 0;
    int   test_mark    = 0;
    int   tests_run    = 0;
    bit   timed_out    = 1'b0;
    int   runs_started = 0;
    int   runs_done    = 0;
    int   reset_edges  = 0;

    tb_clock i_clock (
        .clk (clk)
    );

    cholesky_top i_cholesky_top (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid),
        .busy    (busy)
    );

    // Run bookkeeping
    always @(posedge clk) begin
        if (rst) reset_edges <= reset_edges + 1;
        if (a_valid && !busy) runs_started <= runs_started + 1;
        if (l_valid) runs_done <= runs_done + 1;
    end

    // Helpers
    // --------------------
    function automatic fix_t word_of(input mat_t m, input int e);
        return m[e*`CHOL_WORD +: `CHOL_WORD];
    endfunction

    function automatic int tri_pos(input int r, input int c);
        return r * (r + 1) / 2 + c;
    endfunction

    task automatic report_l_mismatch(input mat_t got, input mat_t want);
        errors++;
        for (int e = 0; e < `CHOL_ELEMS; e++) begin
            if (word_of(got, e) !== word_of(want, e)) begin
                $display("ERROR l word %0d = %h, expected %h",
                         e, word_of(got, e), word_of(want, e));
            end
        end
    endtask

    // Expected factor, column by column in Q16.16
    task automatic cholesky_model(input mat_t am, output mat_t lm);
        fix_t   lw [`CHOL_ELEMS];
        fix_t   res;
        longint acc;
        longint rad;
        longint lo;
        longint hi;
        longint mid;
        lm = '0;
        for (int j = 0; j < `CHOL_N; j++) begin
            for (int i = j; i < `CHOL_N; i++) begin
                acc = longint'(word_of(am, tri_pos(i, j))) <<< `CHOL_FRAC;
                for (int k = 0; k < j; k++) begin
                    acc -= longint'(lw[tri_pos(i, k)]) * longint'(lw[tri_pos(j, k)]);
                end
                res = fix_t'(acc >>> `CHOL_FRAC);
                if (i == j) begin
                    // Largest integer whose square stays under res * 2^16
                    rad = (res < 0) ? 0 : (longint'(res) <<< `CHOL_FRAC);
                    lo  = 0;
                    hi  = longint'(1) << 24;
                    while (lo < hi) begin
                        mid = (lo + hi + 1) / 2;
                        if (mid * mid <= rad) lo = mid;
                        else hi = mid - 1;
                    end
                    lw[tri_pos(i, j)] = fix_t'(lo);
                end else if (lw[tri_pos(j, j)] == 0) begin
                    lw[tri_pos(i, j)] = '0;
                end else begin
                    lw[tri_pos(i, j)] = fix_t'((longint'(res) <<< `CHOL_FRAC)
                                               / longint'(lw[tri_pos(j, j)]));
                end
                lm[tri_pos(i, j)*`CHOL_WORD +: `CHOL_WORD] = lw[tri_pos(i, j)];
            end
        end
    endtask

    // A = M * M^T, M lower triangular with a dominant diagonal
    task automatic make_spd(output mat_t am);
        fix_t   m [`CHOL_N][`CHOL_N];
        longint sum;
        for (int i = 0; i < `CHOL_N; i++) begin
            for (int j = 0; j < `CHOL_N; j++) begin
                if (j == i) m[i][j] = fix_t'(32'h1_0000 + ($urandom % 32'h3_0000));
                else if (j < i) m[i][j] = fix_t'($urandom % 32'h1_0000) - fix_t'(32'h8000);
                else m[i][j] = '0;
            end
        end
        am = '0;
        for (int i = 0; i < `CHOL_N; i++) begin
            for (int j = 0; j <= i; j++) begin
                sum = 0;
                for (int k = 0; k <= j; k++) begin
                    sum += longint'(m[i][k]) * longint'(m[j][k]);
                end
                am[tri_pos(i, j)*`CHOL_WORD +: `CHOL_WORD] = fix_t'(sum >>> `CHOL_FRAC);
            end
        end
    endtask

    function automatic mat_t diag_matrix();
        int   vals [`CHOL_N] = '{4, 9, 1, 16, 2};
        mat_t am;
        am = '0;
        for (int d = 0; d < `CHOL_N; d++) begin
            am[tri_pos(d, d)*`CHOL_WORD +: `CHOL_WORD] = fix_t'(vals[d] <<< `CHOL_FRAC);
        end
        return am;
    endfunction

    task automatic start_run(input mat_t am);
        @(posedge clk);
        a       <= am;
        a_valid <= 1'b1;
        @(posedge clk);
        a_valid <= 1'b0;  // Accepted on this edge
    endtask

    task automatic wait_l_valid();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < RUN_TIMEOUT) begin
            @(posedge clk);
            seen = l_valid;
            n++;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: no l_valid within %0d cycles", RUN_TIMEOUT);
        end
    endtask

    task automatic run_and_check(input mat_t am);
        cholesky_model(am, exp_l);
        start_run(am);
        wait_l_valid();
    endtask

    task automatic log_test_result(input string name);
        repeat (2) @(posedge clk);  // Let the last assertion actions land
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_mark);
        test_mark = errors;
    endtask

    // Checks
    // --------------------
    reset_quiet: assert property (
        @(posedge clk)
        ((rst && reset_edges > 0) || $fell(rst)) |-> (!busy && !l_valid)
    ) else begin
        errors++;
        $display("ERROR busy=%h l_valid=%h around reset, expected 0",
                 $sampled(busy), $sampled(l_valid));
    end

    result_match: assert property (
        @(posedge clk) disable iff (rst)
        l_valid |-> (l == exp_l)
    ) else report_l_mismatch($sampled(l), $sampled(exp_l));

    one_l_valid_per_run: assert property (
        @(posedge clk) disable iff (rst)
        l_valid |-> (runs_done == runs_started - 1)
    ) else begin
        errors++;
        $display("Extra l_valid pulse: %0d runs accepted, %0d already finished",
                 $sampled(runs_started), $sampled(runs_done));
    end

    busy_after_accept: assert property (
        @(posedge clk) disable iff (rst)
        (a_valid && !busy) |=> busy
    ) else begin
        errors++;
        $display("ERROR busy=%h in the cycle after acceptance, expected 1", $sampled(busy));
    end

    busy_rises_on_accept: assert property (
        @(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(a_valid && !busy)
    ) else begin
        errors++;
        $display("busy rose without an accepted a_valid");
    end

    busy_falls_with_l_valid: assert property (
        @(posedge clk) disable iff (rst)
        $fell(busy) |-> l_valid
    ) else begin
        errors++;
        $display("ERROR l_valid=%h when busy fell, expected 1", $sampled(l_valid));
    end

    // Only a load or a running factorization may touch the store
    l_holds: assert property (
        @(posedge clk) disable iff (rst)
        $changed(l) |-> ($past(busy) || $past(a_valid && !busy))
    ) else begin
        errors++;
        $display("ERROR l changed to %h while the DUT was idle", $sampled(l));
    end

    // Sequence
    // --------------------
    initial begin
        void'($urandom(SEED));
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        exp_l   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        log_test_result("reset");

        run_and_check(diag_matrix());
        log_test_result("diagonal");

        if (!timed_out) begin
            for (int r = 0; r < RANDOM_RUNS && !timed_out; r++) begin
                make_spd(stim_first);
                run_and_check(stim_first);
            end
            log_test_result("random");
        end

        if (!timed_out) begin
            make_spd(stim_first);
            make_spd(stim_second);
            cholesky_model(stim_first, exp_l);
            start_run(stim_first);
            repeat (20) @(posedge clk);
            a       <= stim_second;  // Must be dropped, DUT is busy
            a_valid <= 1'b1;
            @(posedge clk);
            a_valid <= 1'b0;
            wait_l_valid();
            log_test_result("ignored a_valid");
        end

        if (!timed_out) begin
            repeat (IDLE_CYCLES) @(posedge clk);
            make_spd(stim_first);
            run_and_check(stim_first);
            log_test_result("hold between runs");
        end

        repeat (2) @(posedge clk);
        $display("%0d tests, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Period of 40
    always #20 clk = ~clk;

endmodule
